// File: tb.f
+incdir+.
conv_geom_pkg.sv
conv_ctrl_pkg.sv
conv_ifs.sv
pixel_loader.sv
row_sequencer.sv
line_window_buffer.sv
conv_window_top.sv
tb_conv_window.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the window generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_conv_window -o sim_conv_window
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_conv_window)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi

// File: tb_conv_window.sv
// Testbench for the 5x5 window generator with image model, checks and watchdog
`include "conv_consts.svh"

module tb_conv_window import conv_geom_pkg::*; ;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int TAIL_CYCLES  = 40;       // Idle time after done
    // About 1.5k cycles needed for one image
    localparam int MAX_CYCLES   = 10000;
    localparam int ROWS_TOTAL   = `CONV_OUT_W;
    localparam int WINDOWS_ALL  = `CONV_OUT_W * `CONV_OUT_W;

    logic    clk = 1'b0;
    logic    reset_n;
    logic    i_start;
    logic    i_pixel_valid;
    pixel_t  i_pixel;
    logic    i_conv_ready;
    logic    o_done;
    logic    o_conv_valid;
    logic    o_conv_row_start;
    logic    o_conv_row_end;
    window_t o_window;
    logic    any_out;

    pixel_t  image [`CONV_IMG_W][`CONV_IMG_W];   // Reference image
    integer  seed;

    int      exp_row;               // Output row being scanned
    int      exp_col;               // Next expected window column
    int      starts_seen;
    int      windows_seen;
    bit      row_open;
    bit      done_seen;

    assign any_out = o_done | o_conv_valid | o_conv_row_start | o_conv_row_end;

    conv_window_top i_dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_start          (i_start),
        .i_pixel_valid    (i_pixel_valid),
        .i_pixel          (i_pixel),
        .i_conv_ready     (i_conv_ready),
        .o_done           (o_done),
        .o_conv_valid     (o_conv_valid),
        .o_conv_row_start (o_conv_row_start),
        .o_conv_row_end   (o_conv_row_end),
        .o_window         (o_window)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic halt_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // Expected window with row 0 as the top image row
    function automatic window_t image_window(input int row, input int col);
        window_t w;
        for (int i = 0; i < `CONV_KERNEL; i++) begin
            for (int j = 0; j < `CONV_KERNEL; j++) begin
                w[i][j] = image[row + i][col + j];
            end
        end
        return w;
    endfunction

    // Called a drive delay after an edge
    task automatic send_row(input int row);
        for (int c = 0; c < `CONV_IMG_W; c++) begin
            i_pixel_valid = 1'b1;
            i_pixel       = image[row][c];
            @(posedge clk);
            #DRIVE_DELAY;
        end
        i_pixel_valid = 1'b0;
    endtask

    task automatic wait_row_start();
        while (!o_conv_row_start) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    initial begin
        reset_n       = 1'b0;
        i_start       = 1'b0;
        i_pixel_valid = 1'b0;
        i_pixel       = '0;
        seed          = 32'h4cf0_9a26;
        for (int r = 0; r < `CONV_IMG_W; r++) begin
            for (int c = 0; c < `CONV_IMG_W; c++) begin
                image[r][c] = pixel_t'($random(seed));
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        i_start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        i_start = 1'b0;

        for (int r = 0; r < `CONV_INIT_ROWS; r++) begin
            send_row(r);                    // Rows 0..4 back to back
        end
        // One prefetched row per row start
        for (int r = `CONV_INIT_ROWS; r < `CONV_IMG_W; r++) begin
            wait_row_start();
            send_row(r);
        end

        wait (done_seen);
        repeat (TAIL_CYCLES) @(posedge clk);
        $display("Test OK");
        $finish;
    end

    // Random consumer stall at about 75 percent ready
    initial begin
        i_conv_ready = 1'b0;
        @(posedge reset_n);
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            i_conv_ready = (($random(seed) & 3) != 0);
        end
    end

    initial begin
        #(CLK_PERIOD * MAX_CYCLES);
        halt_with_error("timeout: the window scan did not finish in time");
    end

    initial begin
        exp_row      = 0;
        exp_col      = 0;
        starts_seen  = 0;
        windows_seen = 0;
        row_open     = 1'b0;
        done_seen    = 1'b0;
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset_n) begin
            assert (!any_out)
                else halt_with_error("an output pulse was high during reset");
        end else begin
            if (o_conv_row_start) begin
                assert (!row_open && !done_seen)
                    else halt_with_error("row start came inside a row or after done");
                assert (starts_seen < ROWS_TOTAL)
                    else halt_with_error($sformatf("mismatch at time %0t: row start %0d",
                                                   $time, starts_seen + 1));
                starts_seen++;
                row_open = 1'b1;
                exp_col  = 0;
            end
            if (o_conv_valid) begin
                assert (!done_seen)
                    else halt_with_error("a window was produced after done");
                assert (row_open && exp_col < `CONV_OUT_W)
                    else halt_with_error("a window was produced outside an open row");
                assert (o_window == image_window(exp_row, exp_col))
                    else halt_with_error($sformatf(
                        "mismatch at time %0t: window row %0d col %0d is %h, expected %h",
                        $time, exp_row, exp_col, o_window, image_window(exp_row, exp_col)));
                exp_col++;
                windows_seen++;
            end
            if (o_conv_row_end) begin
                assert (exp_col == `CONV_OUT_W)
                    else halt_with_error($sformatf(
                        "mismatch at time %0t: row %0d ended after %0d windows",
                        $time, exp_row, exp_col));
                row_open = 1'b0;
                exp_row++;
            end
            if (o_done) begin
                assert (!done_seen && !row_open)
                    else halt_with_error("done came twice or inside an open row");
                assert (starts_seen == ROWS_TOTAL && windows_seen == WINDOWS_ALL)
                    else halt_with_error($sformatf(
                        "mismatch at time %0t: done after %0d rows and %0d windows",
                        $time, starts_seen, windows_seen));
                done_seen = 1'b1;
            end
        end
    end

    a_quiet_at_release: assert property (
        @(posedge clk) $rose(reset_n) |-> !any_out
    ) else halt_with_error("an output pulse was high as reset was released");

    a_quiet_after_release: assert property (
        @(posedge clk) $rose(reset_n) |=> !any_out
    ) else halt_with_error("an output pulse was high in the first cycle after reset");

    a_stall_gap: assert property (
        @(posedge clk) disable iff (!reset_n)
        !i_conv_ready |=> !o_conv_valid
    ) else halt_with_error("a window followed an edge with ready low");

    a_end_with_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_conv_row_end |-> o_conv_valid
    ) else halt_with_error("row end was not aligned with a valid window");

    a_done_single: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_done |=> !o_done
    ) else halt_with_error("done stayed high for more than one cycle");

endmodule

// File: conv_window_top.sv
// Top level of the 5x5 window generator
`include "conv_consts.svh"

module conv_window_top import conv_geom_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    i_start,
    input  logic    i_pixel_valid,
    input  pixel_t  i_pixel,
    input  logic    i_conv_ready,
    output logic    o_done,
    output logic    o_conv_valid,
    output logic    o_conv_row_start,
    output logic    o_conv_row_end,
    output window_t o_window
);

    logic load_init;                // Sequencer in initial load
    logic init_loaded;
    logic prefetch_arm;
    logic prefetch_busy;

    lb_write_if lb_wr ();
    lb_read_if  lb_rd ();

    pixel_loader u_loader (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_pixel_valid   (i_pixel_valid),
        .i_pixel         (i_pixel),
        .i_start         (i_start),
        .i_load_init     (load_init),
        .i_prefetch_arm  (prefetch_arm),
        .o_init_loaded   (init_loaded),
        .o_prefetch_busy (prefetch_busy),
        .wr              (lb_wr.loader)
    );

    row_sequencer u_seq (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_start          (i_start),
        .i_conv_ready     (i_conv_ready),
        .i_init_loaded    (init_loaded),
        .i_prefetch_busy  (prefetch_busy),
        .o_load_init      (load_init),
        .o_prefetch_arm   (prefetch_arm),
        .o_conv_row_start (o_conv_row_start),
        .o_conv_row_end   (o_conv_row_end),
        .o_done           (o_done),
        .rd               (lb_rd.scan)
    );

    line_window_buffer u_buf (
        .clk          (clk),
        .reset_n      (reset_n),
        .wr           (lb_wr.store),
        .rd           (lb_rd.store),
        .o_conv_valid (o_conv_valid)
    );

    assign o_window = lb_rd.window;

endmodule

// File: line_window_buffer.sv
// Six-line pixel memory with registered 5x5 window capture
`include "conv_consts.svh"

module line_window_buffer import conv_geom_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    lb_write_if.store   wr,
    lb_read_if.store    rd,
    output logic        o_conv_valid
);

    pixel_t    mem [`CONV_LINES][`CONV_IMG_W];
    line_idx_t tap_line [`CONV_KERNEL];     // Physical line per window row
    window_t   window_q;
    logic      wr_hits_window;

    // Map window rows onto the ring, modulo 6
    always_comb begin
        logic [3:0] sum;

        wr_hits_window = 1'b0;
        for (int r = 0; r < `CONV_KERNEL; r++) begin
            sum = {1'b0, rd.rd_base} + 4'(r);
            if (sum >= 4'(`CONV_LINES)) begin
                tap_line[r] = line_idx_t'(sum - 4'(`CONV_LINES));
            end else begin
                tap_line[r] = line_idx_t'(sum);
            end
            if (wr.wr_en && (wr.wr_line == tap_line[r])) begin
                wr_hits_window = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_line][wr.wr_col] <= wr.wr_data;
        end

        if (rd.fetch) begin
            for (int r = 0; r < `CONV_KERNEL; r++) begin
                for (int c = 0; c < `CONV_KERNEL; c++) begin
                    // Column never passes 31 since rd_col tops out at 27
                    window_q[r][c] <= mem[tap_line[r]][rd.rd_col + col_t'(c)];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_conv_valid <= 1'b0;
        end else begin
            o_conv_valid <= rd.fetch;           // Window valid one cycle later
        end
    end

    assign rd.window = window_q;

    // Prefetch must only touch the line outside the active window
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (!reset_n)
        rd.fetch |-> !wr_hits_window
    );

endmodule

// File: row_sequencer.sv
// Row scan FSM with window column, output row and read base
`include "conv_consts.svh"

module row_sequencer import conv_geom_pkg::*, conv_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_start,
    input  logic        i_conv_ready,
    input  logic        i_init_loaded,
    input  logic        i_prefetch_busy,
    output logic        o_load_init,
    output logic        o_prefetch_arm,
    output logic        o_conv_row_start,
    output logic        o_conv_row_end,
    output logic        o_done,
    lb_read_if.scan     rd
);

    seq_state_e state;
    seq_state_e state_d;
    col_t       win_col;                    // Left column of next window
    col_t       out_row;                    // Output row 0..27
    line_idx_t  rd_base;
    logic       last_col;
    logic       last_row;

    assign last_col = (win_col == col_t'(`CONV_OUT_W - 1));
    assign last_row = (out_row == col_t'(`CONV_OUT_W - 1));

    // One window per ready edge while scanning
    assign rd.fetch   = (state == SEQ_CONV_ROW) && i_conv_ready;
    assign rd.rd_col  = win_col;
    assign rd.rd_base = rd_base;

    assign o_load_init = (state == SEQ_LOAD_INIT);

    always_comb begin
        state_d = state;
        case (state)
            SEQ_IDLE: begin
                if (i_start) state_d = SEQ_LOAD_INIT;
            end
            SEQ_LOAD_INIT: begin
                if (i_init_loaded) state_d = SEQ_CONV_ROW;
            end
            SEQ_CONV_ROW: begin
                if (rd.fetch && last_col) begin
                    state_d = last_row ? SEQ_FINISH : SEQ_ROLL;
                end
            end
            SEQ_ROLL: begin
                // Next row needs the prefetched line in place
                if (!i_prefetch_busy) state_d = SEQ_CONV_ROW;
            end
            SEQ_FINISH: begin
                state_d = SEQ_IDLE;
            end
            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state            <= SEQ_IDLE;
            win_col          <= '0;
            out_row          <= '0;
            rd_base          <= '0;
            o_prefetch_arm   <= 1'b0;
            o_conv_row_start <= 1'b0;
            o_conv_row_end   <= 1'b0;
            o_done           <= 1'b0;
        end else begin
            state <= state_d;

            // Pulses default low
            o_prefetch_arm   <= 1'b0;
            o_conv_row_start <= 1'b0;
            o_conv_row_end   <= 1'b0;
            o_done           <= 1'b0;

            case (state)
                SEQ_IDLE: begin
                    if (i_start) begin
                        win_col <= '0;
                        out_row <= '0;
                        rd_base <= '0;
                    end
                end
                SEQ_LOAD_INIT: begin
                    if (i_init_loaded) begin
                        o_conv_row_start <= 1'b1;       // Output row 0
                        o_prefetch_arm   <= 1'b1;       // Fetch image row 5
                    end
                end
                SEQ_CONV_ROW: begin
                    if (rd.fetch) begin
                        if (last_col) begin
                            win_col        <= '0;
                            o_conv_row_end <= 1'b1;     // Lines up with 28th valid
                        end else begin
                            win_col <= win_col + 1'b1;
                        end
                    end
                end
                SEQ_ROLL: begin
                    if (!i_prefetch_busy) begin
                        out_row          <= out_row + 1'b1;
                        o_conv_row_start <= 1'b1;
                        o_prefetch_arm   <= 1'b1;
                        // Drop oldest line from the window
                        if (rd_base == line_idx_t'(`CONV_LINES - 1)) begin
                            rd_base <= '0;
                        end else begin
                            rd_base <= rd_base + 1'b1;
                        end
                    end
                end
                SEQ_FINISH: begin
                    o_done <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    a_fetch_in_row: assert property (
        @(posedge clk) disable iff (!reset_n)
        rd.fetch |-> (state == SEQ_CONV_ROW)
    );

    // Window must fit inside the image
    a_col_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        rd.rd_col <= col_t'(`CONV_OUT_W - 1)
    );

endmodule

// File: pixel_loader.sv
// Pixel loader that fills the line-buffer ring during initial load and prefetch
`include "conv_consts.svh"

module pixel_loader import conv_geom_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          i_pixel_valid,
    input  pixel_t        i_pixel,
    input  logic          i_start,
    input  logic          i_load_init,
    input  logic          i_prefetch_arm,
    output logic          o_init_loaded,
    output logic          o_prefetch_busy,
    lb_write_if.loader    wr
);

    col_t      wr_col;          // Next column to write
    row_t      next_row;        // Next image row expected
    line_idx_t wr_line;
    logic      pf_busy;         // Armed row not yet complete
    logic      rows_left;
    logic      pf_active;
    logic      accept;
    logic      row_last;

    assign rows_left = (next_row < row_t'(`CONV_IMG_W));

    // An arm in this cycle already opens the window for pixels
    assign pf_active = pf_busy || (i_prefetch_arm && rows_left);
    assign accept    = i_pixel_valid && (i_load_init || pf_active);
    assign row_last  = (wr_col == col_t'(`CONV_IMG_W - 1));

    // Last pixel of the last initial row
    assign o_init_loaded = i_load_init && i_pixel_valid && row_last &&
                           (next_row == row_t'(`CONV_INIT_ROWS - 1));
    assign o_prefetch_busy = pf_busy;

    assign wr.wr_en   = accept;
    assign wr.wr_line = wr_line;
    assign wr.wr_col  = wr_col;
    assign wr.wr_data = i_pixel;

    always_ff @(posedge clk) begin
        if (!reset_n || i_start) begin
            wr_col   <= '0;
            next_row <= '0;
            wr_line  <= '0;
            pf_busy  <= 1'b0;
        end else begin
            if (accept) begin
                if (row_last) begin
                    wr_col   <= '0;
                    next_row <= next_row + 1'b1;
                    // Wrap around the ring
                    if (wr_line == line_idx_t'(`CONV_LINES - 1)) begin
                        wr_line <= '0;
                    end else begin
                        wr_line <= wr_line + 1'b1;
                    end
                end else begin
                    wr_col <= wr_col + 1'b1;
                end
            end

            if (accept && row_last && !i_load_init) begin
                pf_busy <= 1'b0;                    // Prefetched row complete
            end else if (i_prefetch_arm && rows_left) begin
                pf_busy <= 1'b1;
            end
        end
    end

    // Ring index must stay inside the six physical lines
    a_wr_line_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        wr.wr_en |-> (wr.wr_line < line_idx_t'(`CONV_LINES))
    );

endmodule

// File: conv_ifs.sv
// Line-buffer write and window read interfaces
`include "conv_consts.svh"

interface lb_write_if import conv_geom_pkg::*; ();

    logic      wr_en;
    line_idx_t wr_line;         // Ring line being filled
    col_t      wr_col;
    pixel_t    wr_data;

    // Loader side
    modport loader (
        output wr_en,
        output wr_line,
        output wr_col,
        output wr_data
    );

    // Memory side
    modport store (
        input  wr_en,
        input  wr_line,
        input  wr_col,
        input  wr_data
    );

endinterface

interface lb_read_if import conv_geom_pkg::*; ();

    logic      fetch;           // Capture a window at this edge
    line_idx_t rd_base;         // Line holding the top window row
    col_t      rd_col;          // Left window column
    window_t   window;

    modport scan (
        output fetch,
        output rd_base,
        output rd_col,
        input  window
    );

    modport store (
        input  fetch,
        input  rd_base,
        input  rd_col,
        output window
    );

endinterface

// File: conv_ctrl_pkg.sv
// Sequencer state encoding
`include "conv_consts.svh"

package conv_ctrl_pkg;

    // Row scan FSM
    typedef enum logic [2:0] {
        SEQ_IDLE      = 3'd0,   // Waiting for start
        SEQ_LOAD_INIT = 3'd1,   // First rows streaming in
        SEQ_CONV_ROW  = 3'd2,   // Emitting windows of one output row
        SEQ_ROLL      = 3'd3,   // Waiting on prefetch, then step base
        SEQ_FINISH    = 3'd4    // One cycle to raise done
    } seq_state_e;

endpackage

// File: conv_geom_pkg.sv
// Pixel, window, column, line-index and row types
`include "conv_consts.svh"

package conv_geom_pkg;

    // Signed sample as seen by the convolution datapath
    typedef logic signed [`CONV_PIX_BITS-1:0] pixel_t;

    // Indexed [row][col], row 0 is the oldest line of the window
    typedef pixel_t [`CONV_KERNEL-1:0][`CONV_KERNEL-1:0] window_t;

    typedef logic [$clog2(`CONV_IMG_W)-1:0] col_t;        // 0..31

    // Selects one of the ring lines
    typedef logic [$clog2(`CONV_LINES)-1:0] line_idx_t;

    // One extra bit so that "all rows taken" is 32
    typedef logic [$clog2(`CONV_IMG_W):0] row_t;

endpackage

// File: conv_consts.svh
// Geometry constants for the 5x5 window generator
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Input image is square
`define CONV_IMG_W      32

// Window edge length
`define CONV_KERNEL     5

// Lines in the buffer ring, one more than the kernel for prefetch
`define CONV_LINES      6

// Valid window positions per row and per column
`define CONV_OUT_W      28

`define CONV_PIX_BITS   8       // Bits per pixel

// Rows that must be resident before the first window
`define CONV_INIT_ROWS  5

`endif
